// ==== Makefile ====
# flip history subsystem, Verilator flow

TOP := flip_history_tb

.PHONY: lint build sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP)

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP) -o sim

# status comes from the pass line in the output
sim: build
	@out="$$(./obj_dir/sim 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== dv/flip_history_properties.sv ====
// flip history timing properties
`default_nettype none

`include "sat_consts.svh"

module flip_history_properties (
    input wire                clk,
    input wire                reset_i,
    input wire                eval_valid_i,
    input wire                break_valid_i,
    input sat_pkg::slot_idx_t wr_ptr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed property count, read by the testbench at the end
    int unsigned fail_count = 0;

    // result pipeline flushed by reset
    reset_low: assert property (@(posedge clk) reset_i |=> !break_valid_i)
        else begin
            $error("break_valid_o high right after a reset cycle");
            fail_count++;
        end

    // fixed two cycle evaluation latency, no extra pulses
    eval_latency: assert property (@(posedge clk) disable iff (reset_i)
        break_valid_i == $past(eval_valid_i, 2))
        else begin
            $error("break_valid_o does not follow eval_valid_i by two cycles");
            fail_count++;
        end

    // rotation pointer wraps at NSAT
    ptr_range: assert property (@(posedge clk) disable iff (reset_i) wr_ptr_i < `NSAT)
        else begin
            $error("slot pointer out of range");
            fail_count++;
        end

endmodule

bind flip_history_top flip_history_properties u_props (
    .clk           (clk),
    .reset_i       (reset_i),
    .eval_valid_i  (eval_valid_i),
    .break_valid_i (break_valid_o),
    .wr_ptr_i      (wr_ptr)
);

`default_nettype wire

// ==== dv/flip_history_tb.sv ====
// flip history testbench
`default_nettype none

`include "sat_consts.svh"

module flip_history_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [`LIT_ADDR_W-1:0] var_addr_t;

    // literals drawn from a small pool so clauses share variables
    localparam int POOL_MAX   = 15;
    localparam int WAIT_LIMIT = 16;

    logic                 clk = 1'b0;
    logic                 reset_i;
    logic                 tbl_we_i;
    var_addr_t            tbl_var_i;
    logic [4:0]           tbl_entry_i;
    sat_pkg::clause_u     tbl_clause_i;
    logic                 asg_we_i;
    var_addr_t            asg_var_i;
    logic                 asg_val_i;
    logic                 flip_valid_i;
    var_addr_t            flip_var_i;
    logic                 eval_valid_i;
    sat_pkg::slot_idx_t   eval_slot_i;
    logic                 break_valid_o;
    logic [4:0]           break_count_o;

    // reference model
    sat_pkg::clause_set_t model_tbl [`NUM_VARS];
    sat_pkg::clause_set_t model_slots [`NSAT];
    logic [`NUM_VARS-1:0] model_bits;
    int                   model_ptr;

    always #2 clk = ~clk;

    flip_history_top uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .tbl_we_i      (tbl_we_i),
        .tbl_var_i     (tbl_var_i),
        .tbl_entry_i   (tbl_entry_i),
        .tbl_clause_i  (tbl_clause_i),
        .asg_we_i      (asg_we_i),
        .asg_var_i     (asg_var_i),
        .asg_val_i     (asg_val_i),
        .flip_valid_i  (flip_valid_i),
        .flip_var_i    (flip_var_i),
        .eval_valid_i  (eval_valid_i),
        .eval_slot_i   (eval_slot_i),
        .break_valid_o (break_valid_o),
        .break_count_o (break_count_o)
    );

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input int got, input int want);
        assert (got == want) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want);
            abort_run();
        end
    endtask

    task automatic clear_model();
        foreach (model_tbl[v]) begin
            model_tbl[v] = '0;
        end
        foreach (model_slots[s]) begin
            model_slots[s] = '0;
        end
        model_bits = '0;
        model_ptr  = 0;
    endtask

    // broken when some literal is present and none of them is true
    function automatic int model_breaks(input sat_pkg::clause_set_t set,
                                        input logic [`NUM_VARS-1:0] bits);
        int                total;
        bit                any_used;
        bit                any_true;
        sat_pkg::literal_t lit;
        total = 0;
        for (int c = 0; c < `MAX_CLAUSES_PER_VAR; c++) begin
            any_used = 1'b0;
            any_true = 1'b0;
            for (int l = 0; l < `NSAT; l++) begin
                lit = set[c].lits[l];
                if (lit.addr != '0) begin
                    any_used = 1'b1;
                    if ((bits[lit.addr] ^ lit.negate) == 1'b1) begin
                        any_true = 1'b1;
                    end
                end
            end
            if (any_used && !any_true) begin
                total++;
            end
        end
        return total;
    endfunction

    // some clauses empty, some literal positions unused
    function automatic sat_pkg::clause_u random_clause(input int own_var);
        sat_pkg::clause_u cl;
        cl = '0;
        if ($urandom_range(4) == 0) begin
            return cl;
        end
        cl.split.flipped.negate = 1'($urandom_range(1));
        cl.split.flipped.addr   = var_addr_t'(own_var);
        for (int k = 0; k < `NSAT - 1; k++) begin
            if ($urandom_range(3) != 0) begin
                cl.split.others[k].negate = 1'($urandom_range(1));
                cl.split.others[k].addr   = var_addr_t'($urandom_range(POOL_MAX, 1));
            end
        end
        return cl;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        reset_i <= 1'b1;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        clear_model();
    endtask

    task automatic load_entry(input int v, input int entry, input sat_pkg::clause_u cl);
        @(posedge clk);
        tbl_we_i     <= 1'b1;
        tbl_var_i    <= var_addr_t'(v);
        tbl_entry_i  <= 5'(entry);
        tbl_clause_i <= cl;
        @(posedge clk);
        tbl_we_i <= 1'b0;
        model_tbl[v][entry] = cl;
    endtask

    // entries from n upward stay empty
    task automatic load_variable(input int v, input int n);
        for (int e = 0; e < n; e++) begin
            load_entry(v, e, random_clause(v));
        end
    endtask

    task automatic write_bit(input int v, input bit val);
        @(posedge clk);
        asg_we_i  <= 1'b1;
        asg_var_i <= var_addr_t'(v);
        asg_val_i <= val;
        @(posedge clk);
        asg_we_i <= 1'b0;
        model_bits[v] = val;
    endtask

    task automatic randomize_assignment();
        for (int v = 1; v <= POOL_MAX; v++) begin
            write_bit(v, 1'($urandom_range(1)));
        end
    endtask

    task automatic fill_pool(input bit val);
        for (int v = 1; v <= POOL_MAX; v++) begin
            write_bit(v, val);
        end
    endtask

    // one strobe per cycle, then the settle gap before any evaluation
    task automatic flip_burst(input int vars [$]);
        foreach (vars[i]) begin
            @(posedge clk);
            flip_valid_i <= 1'b1;
            flip_var_i   <= var_addr_t'(vars[i]);
            model_slots[model_ptr] = model_tbl[vars[i]];
            model_ptr = (model_ptr + 1) % `NSAT;
            model_bits[vars[i]] = ~model_bits[vars[i]];
        end
        @(posedge clk);
        flip_valid_i <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    // strobe, wait for the pulse, check latency, count and pulse width
    task automatic evaluate_slot(input int slot);
        int edges;
        bit seen;
        int expected;
        expected = model_breaks(model_slots[slot], model_bits);
        @(posedge clk);
        eval_valid_i <= 1'b1;
        eval_slot_i  <= sat_pkg::slot_idx_t'(slot);
        edges = 0;
        seen  = 1'b0;
        // edges counted from the one that raised the strobe
        while (!seen && edges < WAIT_LIMIT) begin
            @(posedge clk);
            eval_valid_i <= 1'b0;
            edges++;
            @(negedge clk);
            seen = break_valid_o;
        end
        assert (seen) else begin
            $display("timeout: no break_valid_o pulse after evaluating slot %0d", slot);
            abort_run();
        end
        check_hex("break_valid_o latency", edges, 2);
        check_hex("break_count_o", int'(break_count_o), expected);
        @(negedge clk);
        check_hex("break_valid_o", int'(break_valid_o), 0);
    endtask

    task automatic check_all_slots();
        for (int s = 0; s < `NSAT; s++) begin
            evaluate_slot(s);
        end
    endtask

    task automatic test_empty_after_reset();
        check_all_slots();
    endtask

    // pointer is 0 here so the flip lands in slot 0
    task automatic test_single_flip();
        int vars [$];
        load_variable(4, 14);
        randomize_assignment();
        vars.push_back(4);
        flip_burst(vars);
        evaluate_slot(0);
    endtask

    // three flips on consecutive cycles after a fresh reset fill slots 0..2
    task automatic test_flip_burst();
        int vars [$];
        apply_reset();
        vars.push_back(7);
        vars.push_back(9);
        vars.push_back(12);
        foreach (vars[i]) begin
            load_variable(vars[i], 12 + 3 * i);
        end
        randomize_assignment();
        flip_burst(vars);
        check_all_slots();
    endtask

    // fourth flip wraps to slot 0 and leaves slots 1 and 2 untouched
    task automatic test_overwrite_oldest();
        int vars [$];
        load_variable(2, `MAX_CLAUSES_PER_VAR);
        vars.push_back(2);
        flip_burst(vars);
        check_all_slots();
    endtask

    task automatic test_assignment_rewrites();
        for (int round = 0; round < 4; round++) begin
            randomize_assignment();
            check_all_slots();
        end
        // bit 0 belongs to no variable
        write_bit(0, 1'b1);
        check_all_slots();
        fill_pool(1'b0);
        check_all_slots();
        fill_pool(1'b1);
        check_all_slots();
    endtask

    initial begin
        void'($urandom(83583));
        reset_i      = 1'b1;
        tbl_we_i     = 1'b0;
        tbl_var_i    = '0;
        tbl_entry_i  = '0;
        tbl_clause_i = '0;
        asg_we_i     = 1'b0;
        asg_var_i    = '0;
        asg_val_i    = 1'b0;
        flip_valid_i = 1'b0;
        flip_var_i   = '0;
        eval_valid_i = 1'b0;
        eval_slot_i  = '0;
        clear_model();
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        test_empty_after_reset();
        test_single_flip();
        test_flip_burst();
        test_overwrite_oldest();
        test_assignment_rewrites();
        // bound timing properties must be clean as well
        if (uut.u_props.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d timing property failures", uut.u_props.fail_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/sat_pkg.sv
src/clause_table.sv
src/temporal_buffer.sv
src/assignment_store.sv
src/break_counter.sv
src/flip_history_top.sv
dv/flip_history_properties.sv
dv/flip_history_tb.sv

// ==== src/assignment_store.sv ====
// truth assignment store
`default_nettype none

`include "sat_consts.svh"

module assignment_store (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   load_we_i,
    input  wire [`LIT_ADDR_W-1:0] load_var_i,
    input  wire                   load_val_i,
    input  wire                   toggle_i,
    input  wire [`LIT_ADDR_W-1:0] toggle_var_i,
    output logic [`NUM_VARS-1:0]  bits_o
);

    // one bit per variable, bit 0 belongs to no variable
    logic [`NUM_VARS-1:0] bits_q;

    // flipped value of the toggle target
    logic toggle_val;

    assign toggle_val = ~bits_q[toggle_var_i];

    // load then toggle
    // later assignment wins when both hit one variable
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bits_q <= '0;
        end else begin
            if (load_we_i) begin
                bits_q[load_var_i] <= load_val_i;
            end
            if (toggle_i) begin
                bits_q[toggle_var_i] <= toggle_val;
            end
        end
    end

    // whole vector out for parallel lookup
    assign bits_o = bits_q;

endmodule

`default_nettype wire

// ==== src/break_counter.sv ====
// broken clause counter
`default_nettype none

`include "sat_consts.svh"

module break_counter (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   set_valid_i,
    input  sat_pkg::clause_set_t  set_i,
    input  wire [`NUM_VARS-1:0]   bits_i,
    output logic                  break_valid_o,
    output logic [4:0]            break_count_o
);

    // per literal flags
    logic [`MAX_CLAUSES_PER_VAR-1:0][`NSAT-1:0] lit_used;
    logic [`MAX_CLAUSES_PER_VAR-1:0][`NSAT-1:0] lit_true;

    // one bit per broken clause
    logic [`MAX_CLAUSES_PER_VAR-1:0] broken;

    logic [4:0] count_next;

    // every literal looked up at once
    always_comb begin
        for (int c = 0; c < `MAX_CLAUSES_PER_VAR; c++) begin
            for (int l = 0; l < `NSAT; l++) begin
                // address 0 is an empty literal position
                lit_used[c][l] = (set_i[c].lits[l].addr != '0);
                // true when bit xor negate is 1
                lit_true[c][l] = lit_used[c][l]
                               & (bits_i[set_i[c].lits[l].addr] ^ set_i[c].lits[l].negate);
            end
        end
    end

    // broken means some literal used and none true
    // fully empty clause never counts
    always_comb begin
        for (int c = 0; c < `MAX_CLAUSES_PER_VAR; c++) begin
            broken[c] = (|lit_used[c]) & ~(|lit_true[c]);
        end
    end

    // population count of broken clauses
    always_comb begin
        count_next = '0;
        for (int c = 0; c < `MAX_CLAUSES_PER_VAR; c++) begin
            count_next = count_next + {4'b0, broken[c]};
        end
    end

    // count captured with the assignment as it stands at this edge
    always_ff @(posedge clk) begin
        if (set_valid_i) begin
            break_count_o <= count_next;
        end
    end

    // single cycle result pulse
    always_ff @(posedge clk) begin
        if (reset_i) begin
            break_valid_o <= 1'b0;
        end else begin
            break_valid_o <= set_valid_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/clause_table.sv ====
// per-variable clause table
`default_nettype none

`include "sat_consts.svh"

module clause_table (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   load_we_i,
    input  wire [`LIT_ADDR_W-1:0] load_var_i,
    input  wire [4:0]             load_entry_i,
    input  sat_pkg::clause_u      load_clause_i,
    input  wire                   rd_valid_i,
    input  wire [`LIT_ADDR_W-1:0] rd_var_i,
    output logic                  set_valid_o,
    output sat_pkg::clause_set_t  set_o
);

    // one full clause set per variable
    sat_pkg::clause_set_t mem [`NUM_VARS];

    // marks variables that have seen a load since reset
    // an unmarked variable reads back as an empty set
    logic [`NUM_VARS-1:0] var_loaded;

    // set written on the first load of a variable
    sat_pkg::clause_set_t fresh_set;
    logic                 entry_ok;

    assign entry_ok = (load_entry_i < `MAX_CLAUSES_PER_VAR);

    // only the addressed entry is non-empty
    always_comb begin
        fresh_set = '0;
        fresh_set[load_entry_i] = load_clause_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            var_loaded <= '0;
        end else if (load_we_i && entry_ok) begin
            var_loaded[load_var_i] <= 1'b1;
        end
    end

    // first load clears the stale entries of the variable
    always_ff @(posedge clk) begin
        if (load_we_i && entry_ok) begin
            if (var_loaded[load_var_i]) begin
                mem[load_var_i][load_entry_i] <= load_clause_i;
            end else begin
                mem[load_var_i] <= fresh_set;
            end
        end
    end

    // flip read, whole set one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rd_valid_i) begin
            set_o <= var_loaded[rd_var_i] ? mem[rd_var_i] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            set_valid_o <= 1'b0;
        end else begin
            set_valid_o <= rd_valid_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/flip_history_top.sv ====
// flip history subsystem top
`default_nettype none

`include "sat_consts.svh"

module flip_history_top (
    input  wire                   clk,
    input  wire                   reset_i,
    // clause table load
    input  wire                   tbl_we_i,
    input  wire [`LIT_ADDR_W-1:0] tbl_var_i,
    input  wire [4:0]             tbl_entry_i,
    input  sat_pkg::clause_u      tbl_clause_i,
    // assignment load
    input  wire                   asg_we_i,
    input  wire [`LIT_ADDR_W-1:0] asg_var_i,
    input  wire                   asg_val_i,
    // flip request
    input  wire                   flip_valid_i,
    input  wire [`LIT_ADDR_W-1:0] flip_var_i,
    // evaluation request
    input  wire                   eval_valid_i,
    input  sat_pkg::slot_idx_t    eval_slot_i,
    output logic                  break_valid_o,
    output logic [4:0]            break_count_o
);

    // table to buffer
    sat_pkg::clause_set_t tbl_set;
    logic                 tbl_set_valid;

    // buffer to counter
    sat_pkg::clause_set_t buf_set;
    logic                 buf_valid;

    logic [`NUM_VARS-1:0] asg_bits;

    // slot that takes the next flip
    sat_pkg::slot_idx_t wr_ptr;

    // flip variable lined up with the table output
    logic [`LIT_ADDR_W-1:0] flip_var_q;

    // pointer moves on every buffer write, wraps at NSAT
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
        end else if (tbl_set_valid) begin
            if (wr_ptr == sat_pkg::slot_idx_t'(`NSAT - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        flip_var_q <= flip_var_i;
    end

    clause_table u_clause_table (
        .clk           (clk),
        .reset_i       (reset_i),
        .load_we_i     (tbl_we_i),
        .load_var_i    (tbl_var_i),
        .load_entry_i  (tbl_entry_i),
        .load_clause_i (tbl_clause_i),
        .rd_valid_i    (flip_valid_i),
        .rd_var_i      (flip_var_i),
        .set_valid_o   (tbl_set_valid),
        .set_o         (tbl_set)
    );

    temporal_buffer u_temporal_buffer (
        .clk           (clk),
        .reset_i       (reset_i),
        .write_en_i    (tbl_set_valid),
        .write_index_i (wr_ptr),
        .set_i         (tbl_set),
        .read_en_i     (eval_valid_i),
        .read_index_i  (eval_slot_i),
        .set_o         (buf_set),
        .read_valid_o  (buf_valid)
    );

    // toggle lands on the same edge as the slot write
    assignment_store u_assignment_store (
        .clk          (clk),
        .reset_i      (reset_i),
        .load_we_i    (asg_we_i),
        .load_var_i   (asg_var_i),
        .load_val_i   (asg_val_i),
        .toggle_i     (tbl_set_valid),
        .toggle_var_i (flip_var_q),
        .bits_o       (asg_bits)
    );

    break_counter u_break_counter (
        .clk           (clk),
        .reset_i       (reset_i),
        .set_valid_i   (buf_valid),
        .set_i         (buf_set),
        .bits_i        (asg_bits),
        .break_valid_o (break_valid_o),
        .break_count_o (break_count_o)
    );

endmodule

`default_nettype wire

// ==== src/sat_consts.svh ====
// clause geometry constants
`ifndef SAT_CONSTS_SVH
`define SAT_CONSTS_SVH

// literals per clause
// the temporal buffer keeps one slot per literal position
`define NSAT 3

// variable address width, address 0 means no literal
`define LIT_ADDR_W 11

// clause entries kept per variable in the table
`define MAX_CLAUSES_PER_VAR 20

// width of a temporal buffer slot index
`define NSAT_BITS 2

// depth of the assignment store and the clause table
`define NUM_VARS (1 << `LIT_ADDR_W)

`endif

// ==== src/sat_pkg.sv ====
// literal and clause types
`default_nettype none

`include "sat_consts.svh"

package sat_pkg;

    // one literal, negate bit above the variable address
    // address 0 marks an unused literal
    typedef struct packed {
        logic                   negate;
        logic [`LIT_ADDR_W-1:0] addr;
    } literal_t;

    // storage layout of a clause
    // the flipped variable's own literal sits in the low field
    typedef struct packed {
        literal_t [`NSAT-2:0] others;
        literal_t             flipped;
    } clause_split_t;

    // one clause word, 36 bits at default geometry
    // lits for evaluation, split for storage
    typedef union packed {
        literal_t [`NSAT-1:0] lits;
        clause_split_t        split;
    } clause_u;

    // all clauses of one variable, contents of one slot
    typedef clause_u [`MAX_CLAUSES_PER_VAR-1:0] clause_set_t;

    // temporal buffer slot index
    typedef logic [`NSAT_BITS-1:0] slot_idx_t;

endpackage

`default_nettype wire

// ==== src/temporal_buffer.sv ====
// rotating clause set buffer
`default_nettype none

`include "sat_consts.svh"

module temporal_buffer (
    input  wire                  clk,
    input  wire                  reset_i,
    input  wire                  write_en_i,
    input  sat_pkg::slot_idx_t   write_index_i,
    input  sat_pkg::clause_set_t set_i,
    input  wire                  read_en_i,
    input  sat_pkg::slot_idx_t   read_index_i,
    output sat_pkg::clause_set_t set_o,
    output logic                 read_valid_o
);

    // one clause set per recent flip
    sat_pkg::clause_set_t slots [`NSAT];

    logic write_ok;
    logic read_ok;

    // slot index may exceed the slot count
    assign write_ok = write_en_i && (write_index_i < `NSAT);
    assign read_ok  = (read_index_i < `NSAT);

    // write goes clause by clause through the split view
    // flipped literal and the other literals land separately
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < `NSAT; s++) begin
                slots[s] <= '0;
            end
        end else if (write_ok) begin
            for (int c = 0; c < `MAX_CLAUSES_PER_VAR; c++) begin
                slots[write_index_i][c].split.flipped <= set_i[c].split.flipped;
                slots[write_index_i][c].split.others  <= set_i[c].split.others;
            end
        end
    end

    // read registers the slot as a whole
    // same-edge write to that slot is not yet visible
    always_ff @(posedge clk) begin
        if (read_en_i) begin
            if (read_ok) begin
                set_o <= slots[read_index_i];
            end else begin
                // unknown slot reads as empty
                set_o <= '0;
            end
        end
    end

    // valid follows the read strobe by one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            read_valid_o <= 1'b0;
        end else begin
            read_valid_o <= read_en_i;
        end
    end

endmodule

`default_nettype wire
